// ==== sources.f ====
src/armIsaPkg.sv
src/armPipePkg.sv
src/alu.sv
src/executeStage.sv
src/fetchStage.sv
src/regFile.sv
src/memWriteback.sv
src/pipelineControl.sv
src/armCore.sv
dv/armIsaModel.sv
dv/armCoreTb.sv

// ==== Bender.yml ====
package:
  name: armCore

sources:
  - src/armIsaPkg.sv
  - src/armPipePkg.sv
  - src/alu.sv
  - src/executeStage.sv
  - src/fetchStage.sv
  - src/regFile.sv
  - src/memWriteback.sv
  - src/pipelineControl.sv
  - src/armCore.sv
  - target: test
    files:
      - dv/armIsaModel.sv
      - dv/armCoreTb.sv

// ==== dv/armCoreTb.sv ====
`timescale 1ns/1ps

module armCoreTb;

   localparam int BodyLen = 120;
   localparam armIsaPkg::wordT ResetPc = 32'h0000_0000;

   logic            clk;
   logic            reset;
   logic            memWriteM;
   armIsaPkg::wordT pcF, instrF, aluOutM, writeDataM, readDataM;
   armIsaPkg::wordT instrMem [armIsaModel::ProgWords];
   armIsaPkg::wordT dataMem [armIsaModel::DataWords];
   int              storeIdx, cycles, cycleLimit, valueErrors, otherErrors;

   armCore #(.ResetPc(ResetPc)) i_armCore (
      .clk, .reset, .pcF, .instrF, .memWriteM, .aluOutM, .writeDataM, .readDataM
   );

   // Both memories answer within the cycle
   assign instrF    = instrMem[pcF[9:2]];
   assign readDataM = dataMem[aluOutM[8:2]];

   always #5 clk = ~clk;

   // Outputs sampled at the falling edge while they are stable
   always @(negedge clk) begin
      if (!reset) begin
         cycles++;
         if (cycles == 1) begin
            assert (pcF == ResetPc) else begin
               valueErrors++;
               $display("FAILED reset PC: expected %h, actual %h", ResetPc, pcF);
            end
         end
         // Forward branches only, fetch ends two words past the halt loop
         assert (pcF[1:0] == 2'b00 && pcF < 4 * (armIsaModel::progLen + 2)) else begin
            otherErrors++;
            $display("Fetch address %h lies outside the program", pcF);
         end
         if (memWriteM) begin
            assert (storeIdx < armIsaModel::expCount) else begin
               otherErrors++;
               $display("Store to %h with data %h came after all expected stores",
                        aluOutM, writeDataM);
            end
            if (storeIdx < armIsaModel::expCount) begin
               assert (aluOutM == armIsaModel::expAddr[storeIdx]) else begin
                  valueErrors++;
                  $display("FAILED store address %0d: expected %h, actual %h", storeIdx,
                           armIsaModel::expAddr[storeIdx], aluOutM);
               end
               assert (writeDataM == armIsaModel::expData[storeIdx]) else begin
                  valueErrors++;
                  $display("FAILED store data %0d: expected %h, actual %h", storeIdx,
                           armIsaModel::expData[storeIdx], writeDataM);
               end
            end
            dataMem[aluOutM[8:2]] <= writeDataM;
            storeIdx++;
         end
      end
   end

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      storeIdx    = 0;
      cycles      = 0;
      valueErrors = 0;
      otherErrors = 0;
      armIsaModel::buildProgram(BodyLen);
      armIsaModel::runModel();
      for (int i = 0; i < armIsaModel::ProgWords; i++)   // Halt loop past the end
         instrMem[i] = (i < armIsaModel::progLen) ? armIsaModel::prog[i] : armIsaModel::HaltWord;
      for (int i = 0; i < armIsaModel::DataWords; i++)
         dataMem[i] = armIsaModel::initData(i);
      cycleLimit = 4 * armIsaModel::progLen + 50;

      repeat (5) @(posedge clk);
      reset <= 1'b0;

      while (storeIdx < armIsaModel::expCount && cycles < cycleLimit)
         @(posedge clk);
      if (storeIdx < armIsaModel::expCount) begin
         otherErrors++;
         $display("Timeout after %0d cycles with only %0d of %0d stores seen",
                  cycles, storeIdx, armIsaModel::expCount);
      end else begin
         repeat (20) @(posedge clk);   // Stray stores would show up here
      end

      $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
      if (valueErrors + otherErrors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== dv/armIsaModel.sv ====
package armIsaModel;

   localparam int ProgWords = 256;
   localparam int DataWords = 128;
   localparam armIsaPkg::wordT HaltWord = 32'hEAFF_FFFE;   // B . under AL

   logic [31:0]     lfsr = 32'h10a1_7aa3;
   armIsaPkg::wordT prog [ProgWords];
   int              progLen;
   armIsaPkg::wordT expAddr [ProgWords];
   armIsaPkg::wordT expData [ProgWords];
   int              expCount;

   // Galois LFSR, one step for every bit taken
   function automatic logic [31:0] randBits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic armIsaPkg::wordT initData(int idx);
      return (idx * 32'h9E37_79B9) ^ {idx[15:0], ~idx[15:0]};
   endfunction

   function automatic armIsaPkg::condT randCond();
      logic [3:0] c;
      c = 4'(randBits(4));
      return armIsaPkg::condT'((c == 4'hF) ? 4'hE : c);
   endfunction

   function automatic armIsaPkg::wordT encode(armIsaPkg::condT cond, armIsaPkg::opClassT cls,
         logic imm, logic [3:0] funct, logic sBit, logic [3:0] rn, logic [3:0] rd,
         logic [11:0] operand);
      armIsaPkg::dpMemInstrT w;
      w.cond    = cond;
      w.opClass = cls;
      w.imm     = imm;
      w.funct   = armIsaPkg::dpFunctT'(funct);
      w.sBit    = sBit;
      w.rn      = rn;
      w.rd      = rd;
      w.operand = operand;
      return w;
   endfunction

   function automatic armIsaPkg::wordT encodeBranch(armIsaPkg::condT cond, int offset);
      armIsaPkg::branchInstrT w;
      w.cond    = cond;
      w.opClass = armIsaPkg::ClassBranch;
      w.branch  = 1'b1;
      w.link    = 1'b0;
      w.offset  = offset[23:0];
      return w;
   endfunction

   function automatic void buildProgram(int bodyLen);
      int                 n, bodyEnd, k;
      logic [2:0]         kind;
      logic [1:0]         sel;
      logic               imm, sBit;
      logic [3:0]         funct, rn, rd;
      logic [11:0]        operand;
      armIsaPkg::condT    cond;
      n = 0;
      for (int r = 0; r < 14; r++) begin   // AND rX, rX, #0
         prog[n] = encode(armIsaPkg::AL, armIsaPkg::ClassDp, 1'b1, 4'b0000, 1'b0,
                          4'(r), 4'(r), 12'd0);
         n++;
      end
      for (int r = 0; r < 14; r++) begin
         operand = 12'(randBits(8));
         if (r == 13)
            operand[1:0] = 2'b00;   // Base stays word aligned
         prog[n] = encode(armIsaPkg::AL, armIsaPkg::ClassDp, 1'b1, 4'b1100, 1'b0,
                          4'(r), 4'(r), operand);
         n++;
      end
      bodyEnd = n + bodyLen;
      while (n < bodyEnd) begin
         kind = 3'(randBits(3));
         cond = randBits(1) ? armIsaPkg::AL : randCond();
         if (kind < 3'd5) begin
            sel   = 2'(randBits(2));
            funct = (sel == 2'd0) ? 4'b0100 : (sel == 2'd1) ? 4'b0010 :
                    (sel == 2'd2) ? 4'b0000 : 4'b1100;
            imm     = randBits(1) != 0;
            sBit    = randBits(1) != 0;
            rn      = 4'(randBits(4) % 14);
            rd      = 4'(randBits(4) % 13);
            operand = imm ? 12'(randBits(8)) : 12'(randBits(4) % 14);
            prog[n] = encode(cond, armIsaPkg::ClassDp, imm, funct, sBit, rn, rd, operand);
         end else if (kind < 3'd7) begin   // LDR or STR off r13
            rd      = 4'(randBits(4) % 13);
            operand = 12'(randBits(6) << 2);
            prog[n] = encode(cond, armIsaPkg::ClassMem, 1'b0, 4'b1100, kind == 3'd5,
                             4'd13, rd, operand);
         end else begin
            k = 1 + int'(randBits(2));
            if (k > bodyEnd - n)
               k = bodyEnd - n;
            prog[n] = encodeBranch(randCond(), k - 2);   // Lands k words ahead
         end
         n++;
      end
      for (int r = 0; r < 13; r++) begin
         prog[n] = encode(armIsaPkg::AL, armIsaPkg::ClassMem, 1'b0, 4'b1100, 1'b0,
                          4'd13, 4'(r), 12'(r * 4));
         n++;
      end
      for (int c = 0; c < 15; c++) begin   // One store per condition code
         prog[n] = encode(armIsaPkg::condT'(c), armIsaPkg::ClassMem, 1'b0, 4'b1100, 1'b0,
                          4'd13, 4'(c % 13), 12'(128 + c * 4));
         n++;
      end
      prog[n] = HaltWord;
      progLen = n + 1;
   endfunction

   function automatic logic condHolds(logic [3:0] cond, logic n, logic z, logic c, logic v);
      logic holds;
      case (cond)
         4'h0: holds = z;
         4'h1: holds = !z;
         4'h2: holds = c;
         4'h3: holds = !c;
         4'h4: holds = n;
         4'h5: holds = !n;
         4'h6: holds = v;
         4'h7: holds = !v;
         4'h8: holds = c && !z;
         4'h9: holds = !c || z;
         4'hA: holds = n == v;
         4'hB: holds = n != v;
         4'hC: holds = !z && (n == v);
         4'hD: holds = z || (n != v);
         4'hE: holds = 1'b1;
         default: holds = 1'b0;
      endcase
      return holds;
   endfunction

   // Instruction level run, records every store in program order
   function automatic void runModel();
      armIsaPkg::wordT r [16];
      armIsaPkg::wordT mem [DataWords];
      armIsaPkg::wordT instr, a, b, res, addr;
      logic [32:0]     sum;
      logic            n, z, c, v, cNew, vNew, arith;
      int              pc;
      for (int i = 0; i < 16; i++)
         r[i] = '0;
      for (int i = 0; i < DataWords; i++)
         mem[i] = initData(i);
      {n, z, c, v} = 4'b0000;
      cNew     = 1'b0;
      vNew     = 1'b0;
      expCount = 0;
      pc       = 0;
      while (pc < progLen - 1) begin   // Last word is the halt loop
         instr = prog[pc];
         pc++;
         if (condHolds(instr[31:28], n, z, c, v)) begin
            case (instr[27:26])
               2'b00: begin
                  a     = r[instr[19:16]];
                  b     = instr[25] ? {24'b0, instr[7:0]} : r[instr[3:0]];
                  arith = 1'b1;
                  case (instr[24:21])
                     4'b0100: begin
                        sum  = {1'b0, a} + {1'b0, b};
                        res  = sum[31:0];
                        cNew = sum[32];
                        vNew = (a[31] == b[31]) && (res[31] != a[31]);
                     end
                     4'b0010: begin
                        res  = a - b;
                        cNew = a >= b;   // Carry is not borrow
                        vNew = (a[31] != b[31]) && (res[31] != a[31]);
                     end
                     4'b0000: begin
                        res   = a & b;
                        arith = 1'b0;
                     end
                     default: begin
                        res   = a | b;
                        arith = 1'b0;
                     end
                  endcase
                  r[instr[15:12]] = res;
                  if (instr[20]) begin
                     n = res[31];
                     z = res == '0;
                     if (arith) begin
                        c = cNew;
                        v = vNew;
                     end
                  end
               end
               2'b01: begin
                  addr = r[instr[19:16]] + {20'b0, instr[11:0]};
                  if (instr[20]) begin
                     r[instr[15:12]] = mem[addr[8:2]];
                  end else begin
                     mem[addr[8:2]]    = r[instr[15:12]];
                     expAddr[expCount] = addr;
                     expData[expCount] = r[instr[15:12]];
                     expCount++;
                  end
               end
               default: pc = pc + 1 + int'($signed(instr[23:0]));   // PC+8 relative
            endcase
         end
      end
   endfunction

endpackage

// ==== src/armCore.sv ====
`timescale 1ns/1ps

module armCore #(
   parameter armIsaPkg::wordT ResetPc = 32'h0000_0000
) (
   input  logic            clk,
   input  logic            reset,
   output armIsaPkg::wordT pcF,
   input  armIsaPkg::wordT instrF,
   output logic            memWriteM,
   output armIsaPkg::wordT aluOutM,
   output armIsaPkg::wordT writeDataM,
   input  armIsaPkg::wordT readDataM
);

   armIsaPkg::instrU    instrD;
   armIsaPkg::regIdxT   wa3W;
   armIsaPkg::wordT     pcPlus8D, rd1D, rd2D;
   armIsaPkg::wordT     aluResultE, writeDataE, resultW;
   armPipePkg::flagsT   aluFlagsE;
   armPipePkg::regAddrT regAddrD;
   armPipePkg::exeCtrlT exeCtrlE;
   armPipePkg::fwdCtrlT fwdCtrlE;
   logic                branchTakenE, stallF, stallD, flushD;
   logic                regWriteW, memToRegW;

   pipelineControl i_pipelineControl (
      .clk, .reset, .instrD, .aluFlagsE, .regAddrD, .exeCtrlE, .fwdCtrlE,
      .branchTakenE, .stallF, .stallD, .flushD, .memWriteM, .regWriteW,
      .memToRegW, .wa3W
   );

   fetchStage #(.ResetPc(ResetPc)) i_fetchStage (
      .clk, .reset, .stallF, .stallD, .flushD, .branchTakenE, .aluResultE,
      .pcF, .instrF, .instrD, .pcPlus8D
   );

   regFile i_regFile (
      .clk, .regAddrD, .regWriteW, .wa3W, .resultW, .pcPlus8D, .rd1D, .rd2D
   );

   executeStage i_executeStage (
      .clk, .reset, .stallD, .rd1D, .rd2D, .instrD, .regAddrD, .exeCtrlE,
      .fwdCtrlE, .aluOutM, .resultW, .aluResultE, .writeDataE, .aluFlagsE
   );

   memWriteback i_memWriteback (
      .clk, .reset, .aluResultE, .writeDataE, .readDataM, .memToRegW,
      .aluOutM, .writeDataM, .resultW
   );

endmodule

// ==== src/pipelineControl.sv ====
`timescale 1ns/1ps

module pipelineControl (
   input  logic                clk,
   input  logic                reset,
   input  armIsaPkg::instrU    instrD,
   input  armPipePkg::flagsT   aluFlagsE,
   output armPipePkg::regAddrT regAddrD,
   output armPipePkg::exeCtrlT exeCtrlE,
   output armPipePkg::fwdCtrlT fwdCtrlE,
   output logic                branchTakenE,
   output logic                stallF,
   output logic                stallD,
   output logic                flushD,
   output logic                memWriteM,
   output logic                regWriteW,
   output logic                memToRegW,
   output armIsaPkg::regIdxT   wa3W
);

   typedef struct packed {
      logic              regWrite;
      logic              memWrite;
      logic              memToReg;
      logic              branch;
      logic [1:0]        flagWrite;   // {NZ, CV}
      armIsaPkg::condT   cond;
      armIsaPkg::regIdxT wa3;
   } ctrlT;

   ctrlT                ctrlD, ctrlE;
   armPipePkg::exeCtrlT exeCtrlD;
   armPipePkg::regAddrT regAddrE;
   armPipePkg::flagsT   flags;
   armIsaPkg::regIdxT   wa3M;
   logic                validD, arithD, condExE, flushE, ldrStall;
   logic                regWriteM, memToRegM;

   always_comb begin
      ctrlD        = '0;
      exeCtrlD     = '0;
      validD       = 1'b1;
      arithD       = 1'b0;
      ctrlD.cond   = instrD.dp.cond;
      ctrlD.wa3    = instrD.dp.rd;
      regAddrD.ra1 = instrD.dp.rn;
      regAddrD.ra2 = instrD.dp.operand[3:0];   // Rm for register form
      case (instrD.dp.opClass)
         armIsaPkg::ClassDp: begin
            ctrlD.regWrite     = 1'b1;
            exeCtrlD.aluSrcImm = instrD.dp.imm;
            exeCtrlD.immSel    = armPipePkg::ImmZero8;
            case (instrD.dp.funct)
               armIsaPkg::FunctAdd: exeCtrlD.aluOp = armPipePkg::AluAdd;
               armIsaPkg::FunctSub: exeCtrlD.aluOp = armPipePkg::AluSub;
               armIsaPkg::FunctAnd: exeCtrlD.aluOp = armPipePkg::AluAnd;
               armIsaPkg::FunctOrr: exeCtrlD.aluOp = armPipePkg::AluOr;
               default:             validD = 1'b0;
            endcase
            arithD = (exeCtrlD.aluOp == armPipePkg::AluAdd) ||
                     (exeCtrlD.aluOp == armPipePkg::AluSub);
            ctrlD.flagWrite = {instrD.dp.sBit, instrD.dp.sBit & arithD};
         end
         armIsaPkg::ClassMem: begin
            exeCtrlD.aluSrcImm = 1'b1;
            exeCtrlD.immSel    = armPipePkg::ImmZero12;
            if (instrD.dp.sBit) begin   // LDR
               ctrlD.regWrite = 1'b1;
               ctrlD.memToReg = 1'b1;
            end else begin
               ctrlD.memWrite = 1'b1;
               regAddrD.ra2   = instrD.dp.rd;   // Store data
            end
         end
         armIsaPkg::ClassBranch: begin
            validD             = ~instrD.br.link;   // No BL
            ctrlD.branch       = 1'b1;
            exeCtrlD.aluSrcImm = 1'b1;
            exeCtrlD.immSel    = armPipePkg::ImmBranch;
            regAddrD.ra1       = armIsaPkg::PcReg;
         end
         default: validD = 1'b0;
      endcase
      if (!validD)
         ctrlD = '0;
   end

   // Decode to execute boundary
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ctrlE    <= '0;
         exeCtrlE <= '0;
         regAddrE <= '0;
      end else begin
         ctrlE <= flushE ? '0 : ctrlD;
         if (!stallD) begin
            exeCtrlE <= exeCtrlD;
            regAddrE <= regAddrD;   // Tracks the operand registers in execute
         end
      end
   end

   always_comb begin
      case (ctrlE.cond)
         armIsaPkg::EQ: condExE = flags.z;
         armIsaPkg::NE: condExE = ~flags.z;
         armIsaPkg::CS: condExE = flags.c;
         armIsaPkg::CC: condExE = ~flags.c;
         armIsaPkg::MI: condExE = flags.n;
         armIsaPkg::PL: condExE = ~flags.n;
         armIsaPkg::VS: condExE = flags.v;
         armIsaPkg::VC: condExE = ~flags.v;
         armIsaPkg::HI: condExE = flags.c & ~flags.z;
         armIsaPkg::LS: condExE = ~flags.c | flags.z;
         armIsaPkg::GE: condExE = flags.n == flags.v;
         armIsaPkg::LT: condExE = flags.n != flags.v;
         armIsaPkg::GT: condExE = ~flags.z & (flags.n == flags.v);
         armIsaPkg::LE: condExE = flags.z | (flags.n != flags.v);
         armIsaPkg::AL: condExE = 1'b1;
         default:       condExE = 1'b0;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else if (condExE) begin
         if (ctrlE.flagWrite[1]) begin
            flags.n <= aluFlagsE.n;
            flags.z <= aluFlagsE.z;
         end
         if (ctrlE.flagWrite[0]) begin   // Add and subtract only
            flags.c <= aluFlagsE.c;
            flags.v <= aluFlagsE.v;
         end
      end
   end

   assign branchTakenE = ctrlE.branch & condExE;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         memWriteM <= 1'b0;
         regWriteM <= 1'b0;
         memToRegM <= 1'b0;
         wa3M      <= '0;
         regWriteW <= 1'b0;
         memToRegW <= 1'b0;
         wa3W      <= '0;
      end else begin
         memWriteM <= ctrlE.memWrite & condExE;
         regWriteM <= ctrlE.regWrite & condExE;
         memToRegM <= ctrlE.memToReg;
         wa3M      <= ctrlE.wa3;
         regWriteW <= regWriteM;
         memToRegW <= memToRegM;
         wa3W      <= wa3M;
      end
   end

   // Memory stage has priority, it holds the younger result
   always_comb begin
      fwdCtrlE.fwdA = armPipePkg::FwdRf;
      fwdCtrlE.fwdB = armPipePkg::FwdRf;
      if (regWriteM && regAddrE.ra1 == wa3M)
         fwdCtrlE.fwdA = armPipePkg::FwdAluOutM;
      else if (regWriteW && regAddrE.ra1 == wa3W)
         fwdCtrlE.fwdA = armPipePkg::FwdResultW;
      if (regWriteM && regAddrE.ra2 == wa3M)
         fwdCtrlE.fwdB = armPipePkg::FwdAluOutM;
      else if (regWriteW && regAddrE.ra2 == wa3W)
         fwdCtrlE.fwdB = armPipePkg::FwdResultW;
   end

   // Load in execute feeding the instruction in decode
   assign ldrStall = ctrlE.memToReg &
                     ((ctrlE.wa3 == regAddrD.ra1) | (ctrlE.wa3 == regAddrD.ra2));

   assign stallF = ldrStall;
   assign stallD = ldrStall;
   assign flushD = branchTakenE;
   assign flushE = ldrStall | branchTakenE;

   supportedInExeA: assert property (@(posedge clk) disable iff (reset)
      !flushE |-> validD);

   noStallOnBranchA: assert property (@(posedge clk) disable iff (reset)
      !(stallD && branchTakenE));

endmodule

// ==== src/memWriteback.sv ====
`timescale 1ns/1ps

module memWriteback (
   input  logic            clk,
   input  logic            reset,
   input  armIsaPkg::wordT aluResultE,
   input  armIsaPkg::wordT writeDataE,
   input  armIsaPkg::wordT readDataM,
   input  logic            memToRegW,
   output armIsaPkg::wordT aluOutM,
   output armIsaPkg::wordT writeDataM,
   output armIsaPkg::wordT resultW
);

   armIsaPkg::wordT aluOutW, readDataW;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         aluOutM    <= '0;
         writeDataM <= '0;
         aluOutW    <= '0;
         readDataW  <= '0;
      end else begin
         aluOutM    <= aluResultE;   // Address for loads and stores
         writeDataM <= writeDataE;
         aluOutW    <= aluOutM;
         readDataW  <= readDataM;
      end
   end

   assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile (
   input  logic                clk,
   input  armPipePkg::regAddrT regAddrD,
   input  logic                regWriteW,
   input  armIsaPkg::regIdxT   wa3W,
   input  armIsaPkg::wordT     resultW,
   input  armIsaPkg::wordT     pcPlus8D,
   output armIsaPkg::wordT     rd1D,
   output armIsaPkg::wordT     rd2D
);

   armIsaPkg::wordT regs [14:0];   // r0 to r14

   // Falling edge write so decode sees it the same cycle
   always_ff @(negedge clk) begin
      if (regWriteW)
         regs[wa3W] <= resultW;
   end

   assign rd1D = (regAddrD.ra1 == armIsaPkg::PcReg) ? pcPlus8D : regs[regAddrD.ra1];
   assign rd2D = (regAddrD.ra2 == armIsaPkg::PcReg) ? pcPlus8D : regs[regAddrD.ra2];

   noPcWriteA: assert property (@(negedge clk) regWriteW |-> wa3W != armIsaPkg::PcReg);

endmodule

// ==== src/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage #(
   parameter armIsaPkg::wordT ResetPc = 32'h0000_0000
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             stallF,
   input  logic             stallD,
   input  logic             flushD,
   input  logic             branchTakenE,
   input  armIsaPkg::wordT  aluResultE,   // Branch target
   output armIsaPkg::wordT  pcF,
   input  armIsaPkg::wordT  instrF,
   output armIsaPkg::instrU instrD,
   output armIsaPkg::wordT  pcPlus8D
);

   armIsaPkg::wordT pcPlus4F, pcNextF;

   assign pcPlus4F = pcF + 32'd4;
   assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;
   assign pcPlus8D = pcPlus4F;   // Decode instruction sits one word behind

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         pcF <= ResetPc;
      else if (!stallF)
         pcF <= pcNextF;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         instrD <= '0;
      else if (flushD)
         instrD <= '0;   // Bubble, EQ fails with flags clear
      else if (!stallD)
         instrD <= instrF;
   end

   pcAlignedA: assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00);

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
   input  logic                clk,
   input  logic                reset,
   input  logic                stallD,
   input  armIsaPkg::wordT     rd1D,
   input  armIsaPkg::wordT     rd2D,
   input  armIsaPkg::instrU    instrD,
   input  armPipePkg::regAddrT regAddrD,
   input  armPipePkg::exeCtrlT exeCtrlE,
   input  armPipePkg::fwdCtrlT fwdCtrlE,
   input  armIsaPkg::wordT     aluOutM,
   input  armIsaPkg::wordT     resultW,
   output armIsaPkg::wordT     aluResultE,
   output armIsaPkg::wordT     writeDataE,
   output armPipePkg::flagsT   aluFlagsE
);

   armIsaPkg::wordT     rd1E, rd2E, extImmE, srcAE, srcBE;
   armPipePkg::regAddrT regAddrE;
   logic [23:0]         immFieldE;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd1E      <= '0;
         rd2E      <= '0;
         immFieldE <= '0;
         regAddrE  <= '0;
      end else if (!stallD) begin
         rd1E      <= rd1D;
         rd2E      <= rd2D;
         immFieldE <= instrD.br.offset;   // Low bits serve DP and memory too
         regAddrE  <= regAddrD;
      end
   end

   always_comb begin
      case (exeCtrlE.immSel)
         armPipePkg::ImmZero8:  extImmE = {24'b0, immFieldE[7:0]};
         armPipePkg::ImmZero12: extImmE = {20'b0, immFieldE[11:0]};
         armPipePkg::ImmBranch: extImmE = {{6{immFieldE[23]}}, immFieldE, 2'b00};
         default:               extImmE = '0;
      endcase
   end

   always_comb begin
      case (fwdCtrlE.fwdA)
         armPipePkg::FwdResultW: srcAE = resultW;
         armPipePkg::FwdAluOutM: srcAE = aluOutM;
         default:                srcAE = rd1E;
      endcase
      case (fwdCtrlE.fwdB)
         armPipePkg::FwdResultW: writeDataE = resultW;
         armPipePkg::FwdAluOutM: writeDataE = aluOutM;
         default:                writeDataE = rd2E;
      endcase
   end

   assign srcBE = exeCtrlE.aluSrcImm ? extImmE : writeDataE;

   alu i_alu (
      .a      (srcAE),
      .b      (srcBE),
      .aluOp  (exeCtrlE.aluOp),
      .result (aluResultE),
      .flags  (aluFlagsE)
   );

   // PC+8 operand must come from the read port
   pcNotForwardedA: assert property (@(posedge clk) disable iff (reset)
      regAddrE.ra1 == armIsaPkg::PcReg |-> fwdCtrlE.fwdA == armPipePkg::FwdRf);

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
   input  armIsaPkg::wordT   a,
   input  armIsaPkg::wordT   b,
   input  armPipePkg::aluOpT aluOp,
   output armIsaPkg::wordT   result,
   output armPipePkg::flagsT flags
);

   logic        sub, arith;
   logic [32:0] sum;

   assign sub   = (aluOp == armPipePkg::AluSub);
   assign arith = (aluOp == armPipePkg::AluAdd) | sub;
   assign sum   = {1'b0, a} + {1'b0, sub ? ~b : b} + {32'b0, sub};   // Two's complement

   always_comb begin
      case (aluOp)
         armPipePkg::AluAnd: result = a & b;
         armPipePkg::AluOr:  result = a | b;
         default:            result = sum[31:0];
      endcase
   end

   assign flags.n = result[31];
   assign flags.z = (result == '0);
   assign flags.c = arith & sum[32];   // No borrow on subtract
   assign flags.v = arith & ~(a[31] ^ b[31] ^ sub) & (a[31] ^ sum[31]);

endmodule

// ==== src/armPipePkg.sv ====
package armPipePkg;

   typedef enum logic [1:0] {
      AluAdd,
      AluSub,
      AluAnd,
      AluOr
   } aluOpT;

   typedef enum logic [1:0] {
      ImmZero8,
      ImmZero12,
      ImmBranch    // Sign extend and shift by two
   } immSelT;

   // Operand source in execute
   typedef enum logic [1:0] {
      FwdRf,
      FwdResultW,
      FwdAluOutM
   } fwdSelT;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flagsT;

   typedef struct packed {
      aluOpT  aluOp;
      immSelT immSel;
      logic   aluSrcImm;
   } exeCtrlT;

   typedef struct packed {
      fwdSelT fwdA;
      fwdSelT fwdB;
   } fwdCtrlT;

   typedef struct packed {
      armIsaPkg::regIdxT ra1;
      armIsaPkg::regIdxT ra2;
   } regAddrT;

endpackage

// ==== src/armIsaPkg.sv ====
package armIsaPkg;

   typedef logic [31:0] wordT;
   typedef logic [3:0]  regIdxT;

   localparam regIdxT PcReg = 4'd15;  // Reads as PC+8, never written

   // Condition codes, value 4'hF is unused
   typedef enum logic [3:0] {
      EQ, NE, CS, CC, MI, PL, VS, VC,
      HI, LS, GE, LT, GT, LE, AL
   } condT;

   typedef enum logic [1:0] {
      ClassDp     = 2'b00,
      ClassMem    = 2'b01,
      ClassBranch = 2'b10
   } opClassT;

   typedef enum logic [3:0] {
      FunctAnd = 4'b0000,
      FunctSub = 4'b0010,
      FunctAdd = 4'b0100,
      FunctOrr = 4'b1100
   } dpFunctT;

   // Data processing and load/store share this layout
   typedef struct packed {
      condT        cond;
      opClassT     opClass;
      logic        imm;       // Immediate operand, DP only
      dpFunctT     funct;     // P/U/B/W bits for load/store
      logic        sBit;      // S for DP, L for load/store
      regIdxT      rn;
      regIdxT      rd;
      logic [11:0] operand;
   } dpMemInstrT;

   typedef struct packed {
      condT        cond;
      opClassT     opClass;
      logic        branch;
      logic        link;
      logic [23:0] offset;    // Word offset, sign extended
   } branchInstrT;

   typedef union packed {
      dpMemInstrT  dp;
      branchInstrT br;
   } instrU;

endpackage
